// ==== source/m6502_bus_pkg.sv ====
package m6502_bus_pkg;

   localparam int addr_width = 16;
   localparam int data_width = 8;

   typedef logic [addr_width-1:0] addr_t;
   typedef logic [data_width-1:0] data_t;

   // Low byte of the start address, high byte follows
   localparam addr_t reset_vector = 16'hFFFC;

   typedef enum logic [1:0] {
      access_load  = 2'd0,
      access_store = 2'd1,
      access_fetch = 2'd2   // Single byte, no operand walk
   } access_t;

endpackage

// ==== source/m6502_isa_pkg.sv ====
package m6502_isa_pkg;

   typedef struct packed {
      logic [2:0] aaa;
      logic [2:0] bbb;
      logic [1:0] cc;
   } opcode_fields_t;

   typedef union packed {
      logic [7:0]     raw;
      opcode_fields_t fields;
   } opcode_t;

   typedef enum logic [3:0] {
      mode_idle,
      mode_reset,
      mode_imm,
      mode_zp,
      mode_zp_x,
      mode_zp_y,
      mode_abs,
      mode_abs_x,
      mode_abs_y,
      mode_ind_x,   // (zp,X)
      mode_ind_y,   // (zp),Y
      mode_ind_abs  // JMP (abs)
   } addr_mode_t;

   // Group one fields
   localparam logic [1:0] cc_group_one = 2'b01;
   localparam logic [2:0] aaa_sta      = 3'b100;
   localparam logic [2:0] aaa_lda      = 3'b101;

   localparam logic [2:0] bbb_ind_x = 3'b000;
   localparam logic [2:0] bbb_zp    = 3'b001;
   localparam logic [2:0] bbb_imm   = 3'b010;
   localparam logic [2:0] bbb_abs   = 3'b011;
   localparam logic [2:0] bbb_ind_y = 3'b100;
   localparam logic [2:0] bbb_zp_x  = 3'b101;
   localparam logic [2:0] bbb_abs_y = 3'b110;
   localparam logic [2:0] bbb_abs_x = 3'b111;

   localparam logic [7:0] op_ldx_imm = 8'hA2;
   localparam logic [7:0] op_ldx_zp  = 8'hA6;
   localparam logic [7:0] op_ldx_abs = 8'hAE;
   localparam logic [7:0] op_ldy_imm = 8'hA0;
   localparam logic [7:0] op_ldy_zp  = 8'hA4;
   localparam logic [7:0] op_ldy_abs = 8'hAC;
   localparam logic [7:0] op_jmp_abs = 8'h4C;
   localparam logic [7:0] op_jmp_ind = 8'h6C;

   function automatic logic [1:0] mode_length(addr_mode_t mode);
      case (mode)
         mode_imm, mode_zp, mode_zp_x, mode_zp_y, mode_ind_x, mode_ind_y: return 2'd1;
         mode_abs, mode_abs_x, mode_abs_y, mode_ind_abs: return 2'd2;
         default: return 2'd0;
      endcase
   endfunction

endpackage

// ==== source/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if
   import m6502_bus_pkg::*;
();

   addr_t addr;
   data_t rd_data;
   data_t wr_data;
   logic  rd_req;
   logic  wr_en;
   logic  ready;   // One cycle pulse, ends the request

   modport master (
      output addr, wr_data, rd_req, wr_en,
      input  rd_data, ready
   );

   modport slave (
      input  addr, wr_data, rd_req, wr_en,
      output rd_data, ready
   );

endinterface

// ==== source/addr_req_if.sv ====
`timescale 1ns/1ps

interface addr_req_if
   import m6502_bus_pkg::*;
   import m6502_isa_pkg::*;
();

   logic       valid;
   addr_mode_t mode;
   access_t    access;
   addr_t      operand_addr;   // First operand byte, or opcode for a fetch
   data_t      index_x;
   data_t      index_y;
   data_t      store_data;

   logic       ready;
   logic       done;
   data_t      load_data;
   addr_t      jump_target;

   modport requester (
      output valid, mode, access, operand_addr, index_x, index_y, store_data,
      input  ready, done, load_data, jump_target
   );

   modport server (
      input  valid, mode, access, operand_addr, index_x, index_y, store_data,
      output ready, done, load_data, jump_target
   );

endinterface

// ==== source/m6502_addr_unit.sv ====
`timescale 1ns/1ps

module m6502_addr_unit
   import m6502_bus_pkg::*;
   import m6502_isa_pkg::*;
(
   input logic        clk,
   input logic        reset_n,
   addr_req_if.server req,
   mem_bus_if.master  mem
);

   localparam logic [2:0] s_idle    = 3'd0;
   localparam logic [2:0] s_opr_lo  = 3'd1;
   localparam logic [2:0] s_opr_hi  = 3'd2;
   localparam logic [2:0] s_ptr_lo  = 3'd3;
   localparam logic [2:0] s_ptr_hi  = 3'd4;
   localparam logic [2:0] s_access  = 3'd5;
   localparam logic [2:0] s_done    = 3'd6;

   logic [2:0] state;
   addr_mode_t mode_q;
   access_t    access_q;
   addr_t      opr_addr_q;
   data_t      x_q;
   data_t      y_q;
   data_t      store_q;
   data_t      lo_q;        // Low byte of the word being collected
   addr_t      ptr_q;
   addr_t      ea_q;
   addr_t      word_q;
   data_t      load_data_q;

   data_t zp_x_sum;
   data_t zp_y_sum;
   addr_t ptr_next;
   logic  zp_pointer;

   assign zp_x_sum = mem.rd_data + x_q;   // Wraps inside page 0
   assign zp_y_sum = mem.rd_data + y_q;
   assign zp_pointer = (mode_q == mode_ind_x) || (mode_q == mode_ind_y);
   assign ptr_next = zp_pointer ? {8'h00, ptr_q[7:0] + 8'd1} : ptr_q + 16'd1;

   always_comb
   begin
      mem.addr = ea_q;
      mem.rd_req = 1'b0;
      mem.wr_en = 1'b0;
      case (state)
         s_opr_lo:
         begin
            mem.addr = opr_addr_q;
            mem.rd_req = 1'b1;
         end
         s_opr_hi:
         begin
            mem.addr = opr_addr_q + 16'd1;
            mem.rd_req = 1'b1;
         end
         s_ptr_lo:
         begin
            mem.addr = ptr_q;
            mem.rd_req = 1'b1;
         end
         s_ptr_hi:
         begin
            mem.addr = ptr_next;
            mem.rd_req = 1'b1;
         end
         s_access:
         begin
            mem.wr_en = (access_q == access_store);
            mem.rd_req = (access_q != access_store);
         end
         default:
         begin
         end
      endcase
   end

   assign mem.wr_data = store_q;
   assign req.ready = (state == s_idle);
   assign req.done = (state == s_done);
   assign req.load_data = load_data_q;
   assign req.jump_target = word_q;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         state <= s_idle;
      else
      begin
         case (state)
            s_idle:
               if (req.valid)
               begin
                  mode_q <= req.mode;
                  access_q <= req.access;
                  opr_addr_q <= req.operand_addr;
                  x_q <= req.index_x;
                  y_q <= req.index_y;
                  store_q <= req.store_data;
                  if (req.access == access_fetch || req.mode == mode_imm)
                  begin
                     ea_q <= req.operand_addr;
                     state <= s_access;
                  end
                  else if (req.mode == mode_reset)
                  begin
                     ptr_q <= reset_vector;
                     state <= s_ptr_lo;
                  end
                  else
                     state <= s_opr_lo;
               end
            s_opr_lo:
               if (mem.ready)
               begin
                  lo_q <= mem.rd_data;
                  state <= s_access;
                  case (mode_q)
                     mode_zp: ea_q <= {8'h00, mem.rd_data};
                     mode_zp_x: ea_q <= {8'h00, zp_x_sum};
                     mode_zp_y: ea_q <= {8'h00, zp_y_sum};
                     mode_ind_x:
                     begin
                        ptr_q <= {8'h00, zp_x_sum};
                        state <= s_ptr_lo;
                     end
                     mode_ind_y:
                     begin
                        ptr_q <= {8'h00, mem.rd_data};
                        state <= s_ptr_lo;
                     end
                     default: state <= s_opr_hi;   // Two byte operand
                  endcase
               end
            s_opr_hi:
               if (mem.ready)
               begin
                  word_q <= {mem.rd_data, lo_q};
                  state <= s_access;
                  case (mode_q)
                     mode_abs_x: ea_q <= {mem.rd_data, lo_q} + {8'h00, x_q};
                     mode_abs_y: ea_q <= {mem.rd_data, lo_q} + {8'h00, y_q};
                     mode_ind_abs:
                     begin
                        ptr_q <= {mem.rd_data, lo_q};
                        state <= s_ptr_lo;
                     end
                     default: ea_q <= {mem.rd_data, lo_q};
                  endcase
               end
            s_ptr_lo:
               if (mem.ready)
               begin
                  lo_q <= mem.rd_data;
                  state <= s_ptr_hi;
               end
            s_ptr_hi:
               if (mem.ready)
               begin
                  word_q <= {mem.rd_data, lo_q};
                  state <= s_access;
                  case (mode_q)
                     mode_ind_x: ea_q <= {mem.rd_data, lo_q};
                     mode_ind_y: ea_q <= {mem.rd_data, lo_q} + {8'h00, y_q};
                     default: state <= s_done;   // Vector or JMP pointer word
                  endcase
               end
            s_access:
               if (mem.ready)
               begin
                  if (access_q != access_store)
                     load_data_q <= mem.rd_data;
                  state <= s_done;
               end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

// ==== source/m6502_cpu.sv ====
`timescale 1ns/1ps

module m6502_cpu
   import m6502_bus_pkg::*;
   import m6502_isa_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   mem_bus_if.master mem,
   output logic      halted
);

   localparam logic [3:0] st_boot       = 4'd0;
   localparam logic [3:0] st_reset      = 4'd1;
   localparam logic [3:0] st_reset_wait = 4'd2;
   localparam logic [3:0] st_fetch      = 4'd3;
   localparam logic [3:0] st_fetch_wait = 4'd4;
   localparam logic [3:0] st_decode     = 4'd5;
   localparam logic [3:0] st_execute    = 4'd6;
   localparam logic [3:0] st_exec_wait  = 4'd7;
   localparam logic [3:0] st_halt       = 4'd8;

   logic [3:0] state;
   addr_t      pc;
   data_t      reg_a;
   data_t      reg_x;
   data_t      reg_y;
   opcode_t    opcode;

   addr_mode_t group_mode;
   addr_mode_t dec_mode;
   access_t    dec_access;
   logic       dec_ok;
   logic       dec_jump;
   logic       dec_load_a;
   logic       dec_load_x;
   logic       dec_load_y;

   addr_req_if areq ();

   m6502_addr_unit u_addr_unit (
      .clk     (clk),
      .reset_n (reset_n),
      .req     (areq.server),
      .mem     (mem)
   );

   always_comb
   begin
      case (opcode.fields.bbb)
         bbb_ind_x: group_mode = mode_ind_x;
         bbb_zp:    group_mode = mode_zp;
         bbb_imm:   group_mode = mode_imm;
         bbb_abs:   group_mode = mode_abs;
         bbb_ind_y: group_mode = mode_ind_y;
         bbb_zp_x:  group_mode = mode_zp_x;
         bbb_abs_y: group_mode = mode_abs_y;
         default:   group_mode = mode_abs_x;
      endcase
   end

   always_comb
   begin
      dec_ok = 1'b1;
      dec_mode = mode_idle;
      dec_access = access_load;
      dec_jump = 1'b0;
      dec_load_a = 1'b0;
      dec_load_x = 1'b0;
      dec_load_y = 1'b0;
      if (opcode.fields.cc == cc_group_one && opcode.fields.aaa == aaa_lda)
      begin
         dec_mode = group_mode;
         dec_load_a = 1'b1;
      end
      else if (opcode.fields.cc == cc_group_one && opcode.fields.aaa == aaa_sta
               && opcode.fields.bbb != bbb_imm)
      begin
         dec_mode = group_mode;
         dec_access = access_store;
      end
      else
      begin
         dec_load_x = (opcode.raw == op_ldx_imm) || (opcode.raw == op_ldx_zp)
                      || (opcode.raw == op_ldx_abs);
         dec_load_y = (opcode.raw == op_ldy_imm) || (opcode.raw == op_ldy_zp)
                      || (opcode.raw == op_ldy_abs);
         dec_jump = (opcode.raw == op_jmp_abs) || (opcode.raw == op_jmp_ind);
         case (opcode.raw)
            op_ldx_imm, op_ldy_imm: dec_mode = mode_imm;
            op_ldx_zp, op_ldy_zp:   dec_mode = mode_zp;
            op_ldx_abs, op_ldy_abs: dec_mode = mode_abs;
            op_jmp_abs:             dec_mode = mode_abs;   // Target is the operand word
            op_jmp_ind:             dec_mode = mode_ind_abs;
            default:                dec_ok = 1'b0;
         endcase
      end
   end

   assign areq.valid = (state == st_reset) || (state == st_fetch) || (state == st_execute);
   assign areq.mode = (state == st_reset) ? mode_reset :
                      (state == st_execute) ? dec_mode : mode_idle;
   assign areq.access = (state == st_fetch) ? access_fetch : dec_access;
   assign areq.operand_addr = pc;
   assign areq.index_x = reg_x;
   assign areq.index_y = reg_y;
   assign areq.store_data = reg_a;

   always_ff @(posedge clk)
   begin
      if (state == st_fetch_wait && areq.done)
         opcode <= areq.load_data;
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state <= st_boot;
         halted <= 1'b0;
         pc <= '0;
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
      end
      else
      begin
         case (state)
            st_boot: state <= st_reset;
            st_reset:
               if (areq.ready)
                  state <= st_reset_wait;
            st_reset_wait:
               if (areq.done)
               begin
                  pc <= areq.jump_target;
                  state <= st_fetch;
               end
            st_fetch:
               if (areq.ready)
                  state <= st_fetch_wait;
            st_fetch_wait:
               if (areq.done)
               begin
                  pc <= pc + 16'd1;
                  state <= st_decode;
               end
            st_decode:
               if (dec_ok)
                  state <= st_execute;
               else
               begin
                  halted <= 1'b1;   // Held until reset
                  state <= st_halt;
               end
            st_execute:
               if (areq.ready)
                  state <= st_exec_wait;
            st_exec_wait:
               if (areq.done)
               begin
                  if (dec_load_a)
                     reg_a <= areq.load_data;
                  if (dec_load_x)
                     reg_x <= areq.load_data;
                  if (dec_load_y)
                     reg_y <= areq.load_data;
                  if (dec_jump)
                     pc <= areq.jump_target;
                  else
                     pc <= pc + addr_t'(mode_length(dec_mode));
                  state <= st_fetch;
               end
            st_halt: state <= st_halt;
            default: state <= st_boot;
         endcase
      end
   end

endmodule

// ==== source/m6502_ram.sv ====
`timescale 1ns/1ps

module m6502_ram
   import m6502_bus_pkg::*;
#(
   parameter int WAIT_CYCLES = 1
)
(
   input  logic     clk,
   mem_bus_if.slave bus,
   input  addr_t    host_addr,
   input  logic     host_wr_en,
   input  data_t    host_wr_data,
   output data_t    host_rd_data
);

   data_t      storage [0:2**addr_width-1];
   logic       ready_q;
   logic [3:0] wait_cnt;
   logic       request;

   assign request = bus.rd_req || bus.wr_en;
   assign bus.ready = ready_q;
   assign bus.rd_data = storage[bus.addr];
   assign host_rd_data = storage[host_addr];

   // Counter restarts whenever the bus is idle or a request completes
   always_ff @(posedge clk)
   begin
      if (!request || ready_q)
      begin
         ready_q <= 1'b0;
         wait_cnt <= '0;
      end
      else if (wait_cnt == 4'(WAIT_CYCLES))
         ready_q <= 1'b1;
      else
         wait_cnt <= wait_cnt + 4'd1;
   end

   always_ff @(posedge clk)
   begin
      if (bus.wr_en && ready_q)   // CPU write lands with the ready pulse
         storage[bus.addr] <= bus.wr_data;
      else if (host_wr_en)
         storage[host_addr] <= host_wr_data;
   end

endmodule

// ==== source/m6502_system.sv ====
`timescale 1ns/1ps

module m6502_system
   import m6502_bus_pkg::*;
#(
   parameter int WAIT_CYCLES = 1
)
(
   input  logic  clk,
   input  logic  reset_n,
   input  addr_t host_addr,
   input  logic  host_wr_en,
   input  data_t host_wr_data,
   output data_t host_rd_data,
   output logic  halted
);

   mem_bus_if cpu_bus ();

   m6502_cpu u_cpu (
      .clk     (clk),
      .reset_n (reset_n),
      .mem     (cpu_bus.master),
      .halted  (halted)
   );

   m6502_ram #(
      .WAIT_CYCLES (WAIT_CYCLES)
   ) u_ram (
      .clk          (clk),
      .bus          (cpu_bus.slave),
      .host_addr    (host_addr),
      .host_wr_en   (host_wr_en),
      .host_wr_data (host_wr_data),
      .host_rd_data (host_rd_data)
   );

endmodule

// ==== tb/m6502_ref_model.svh ====
`ifndef M6502_REF_MODEL_SVH
`define M6502_REF_MODEL_SVH

// Mode codes follow the group one bbb field
function automatic addr_t instr_length(logic [2:0] mode);
   if (mode == 3'b011 || mode[2:1] == 2'b11)
      return 16'd3;
   return 16'd2;
endfunction

function automatic addr_t operand_address(addr_t pc, logic [2:0] mode, data_t x, data_t y);
   data_t b1;
   data_t zp;
   data_t zp_next;
   addr_t word;
   b1 = mem_image[pc + 16'd1];
   word = {mem_image[pc + 16'd2], b1};
   zp = (mode == 3'b100) ? b1 : data_t'(b1 + x);
   zp_next = zp + 8'd1;   // Pointer stays in page 0
   case (mode)
      3'b000: return {mem_image[zp_next], mem_image[zp]};
      3'b001: return {8'h00, b1};
      3'b010: return pc + 16'd1;
      3'b011: return word;
      3'b100: return {mem_image[zp_next], mem_image[zp]} + {8'h00, y};
      3'b101: return {8'h00, zp};
      3'b110: return word + {8'h00, y};
      default: return word + {8'h00, x};
   endcase
endfunction

// Runs the image from the reset vector, returns the step count or -1
function automatic int execute_model();
   addr_t      pc;
   addr_t      ptr;
   data_t      a;
   data_t      x;
   data_t      y;
   data_t      op;
   logic [2:0] mode;
   pc = {mem_image[16'hFFFD], mem_image[16'hFFFC]};
   a = 8'h00;
   x = 8'h00;
   y = 8'h00;
   for (int step = 0; step < max_steps; step++)
   begin
      op = mem_image[pc];
      mode = op[4:2];
      case (op)
         8'h4C:
            pc = {mem_image[pc + 16'd2], mem_image[pc + 16'd1]};
         8'h6C:
         begin
            ptr = {mem_image[pc + 16'd2], mem_image[pc + 16'd1]};
            pc = {mem_image[ptr + 16'd1], mem_image[ptr]};   // Full carry on the pointer
         end
         8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4, 8'hAC:
         begin
            if (mode == 3'b000)
               mode = 3'b010;   // LDX and LDY immediate
            if (op[1])
               x = mem_image[operand_address(pc, mode, x, y)];
            else
               y = mem_image[operand_address(pc, mode, x, y)];
            pc = pc + instr_length(mode);
         end
         default:
            if (op[1:0] == 2'b01 && op[7:5] == 3'b101)
            begin
               a = mem_image[operand_address(pc, mode, x, y)];
               pc = pc + instr_length(mode);
            end
            else if (op[1:0] == 2'b01 && op[7:5] == 3'b100 && mode != 3'b010)
            begin
               mem_image[operand_address(pc, mode, x, y)] = a;
               pc = pc + instr_length(mode);
            end
            else
               return step;
      endcase
   end
   return -1;
endfunction

`endif

// ==== tb/tb_m6502_system.sv ====
`timescale 1ns/1ps

module tb_m6502_system
   import m6502_bus_pkg::*;
();

   localparam int    max_cycles = 5000;
   localparam int    max_steps = 1000;
   localparam data_t halt_op = 8'h02;   // Outside the subset

   logic  clk;
   logic  reset_n;
   addr_t host_addr;
   logic  host_wr_en;
   data_t host_wr_data;
   data_t host_rd_data;
   logic  halted;

   data_t  mem_image [0:65535];
   addr_t  cursor;
   data_t  expected_byte;
   logic   compare_en;
   int     steps;
   integer seed;
   data_t  op;

   // Loads, stores and a JMP for the random program
   data_t opcode_pool [0:21] = '{8'hA1, 8'hA5, 8'hA9, 8'hAD, 8'hB1, 8'hB5, 8'hB9, 8'hBD,
                                 8'h81, 8'h85, 8'h8D, 8'h91, 8'h95, 8'h99, 8'h9D,
                                 8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4, 8'hAC, 8'h4C};

   `include "m6502_ref_model.svh"

   m6502_system #(
      .WAIT_CYCLES (2)
   ) u_m6502_system (
      .clk          (clk),
      .reset_n      (reset_n),
      .host_addr    (host_addr),
      .host_wr_en   (host_wr_en),
      .host_wr_data (host_wr_data),
      .host_rd_data (host_rd_data),
      .halted       (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (compare_en)
      begin
         assert (host_rd_data === expected_byte)
         else
         begin
            $display("Error: %0t ns addr %04h expected %02h read %02h",
                     $time, host_addr, expected_byte, host_rd_data);
            $display("tests failed");
            $fatal(1, "RAM contents differ from the reference model");
         end
      end
   end

   task automatic hold_reset();
      @(negedge clk);
      reset_n = 1'b0;
      host_wr_en = 1'b0;
      repeat (8) @(negedge clk);
   endtask

   task automatic load_byte(addr_t a, data_t d);
      @(negedge clk);
      host_addr = a;
      host_wr_data = d;
      host_wr_en = 1'b1;
      mem_image[a] = d;
   endtask

   task automatic set_vector(addr_t start);
      load_byte(reset_vector, start[7:0]);
      load_byte(reset_vector + 16'd1, start[15:8]);
      cursor = start;
   endtask

   task automatic put_instr(data_t opcode, addr_t operand, addr_t len);
      load_byte(cursor, opcode);
      if (len > 16'd1)
         load_byte(cursor + 16'd1, operand[7:0]);
      if (len > 16'd2)
         load_byte(cursor + 16'd2, operand[15:8]);
      cursor = cursor + len;
   endtask

   // Release reset, wait for halt, then let the model catch up
   task automatic run_program();
      int cycles;
      @(negedge clk);
      host_wr_en = 1'b0;
      reset_n = 1'b1;
      cycles = 0;
      while (halted !== 1'b1 && cycles < max_cycles)
      begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1)
      begin
         $display("tests failed");
         $fatal(1, "Timeout: the CPU never halted");
      end
      steps = execute_model();
      if (steps < 0)
      begin
         $display("tests failed");
         $fatal(1, "The reference model never reached an unsupported opcode");
      end
   endtask

   task automatic check_range(addr_t first, addr_t last);
      for (int a = first; a <= last; a++)
      begin
         @(negedge clk);
         host_addr = addr_t'(a);
         expected_byte = mem_image[a];
         compare_en = 1'b1;
      end
      @(negedge clk);
      compare_en = 1'b0;
   endtask

   initial
   begin
      reset_n = 1'b0;
      host_addr = '0;
      host_wr_en = 1'b0;
      host_wr_data = '0;
      compare_en = 1'b0;
      expected_byte = '0;
      seed = 11;

      hold_reset();
      for (int a = 0; a < 65536; a++)
         load_byte(addr_t'(a), data_t'(a[15:8] ^ a[7:0] ^ 8'h5A));

      // Vector and JMP absolute
      set_vector(16'h8000);
      put_instr(8'h4C, 16'h8100, 3);
      put_instr(8'hA9, 16'h0011, 2);   // Only reached if the jump fails
      put_instr(8'h8D, 16'h0300, 3);
      put_instr(halt_op, 16'h0000, 1);
      cursor = 16'h8100;
      put_instr(8'hA9, 16'h00A5, 2);
      put_instr(8'h8D, 16'h0300, 3);
      put_instr(halt_op, 16'h0000, 1);
      run_program();
      check_range(16'h0300, 16'h0301);

      // Immediate, zero page, absolute
      hold_reset();
      load_byte(16'h0010, 8'h3C);
      load_byte(16'h1234, 8'hC3);
      set_vector(16'h8200);
      put_instr(8'hA9, 16'h005A, 2);
      put_instr(8'h85, 16'h0020, 2);
      put_instr(8'hA5, 16'h0010, 2);
      put_instr(8'h8D, 16'h0321, 3);
      put_instr(8'hAD, 16'h1234, 3);
      put_instr(8'h85, 16'h0022, 2);
      put_instr(halt_op, 16'h0000, 1);
      run_program();
      check_range(16'h0020, 16'h0022);
      check_range(16'h0321, 16'h0321);

      // Indexed modes
      hold_reset();
      load_byte(16'h0030, 8'h11);
      load_byte(16'h0031, 8'h01);
      load_byte(16'h0005, 8'h9E);
      load_byte(16'h0500, 8'h02);
      load_byte(16'h0501, 8'h6B);
      load_byte(16'h0502, 8'h03);
      set_vector(16'h8300);
      put_instr(8'hA2, 16'h00F0, 2);
      put_instr(8'hA4, 16'h0030, 2);
      put_instr(8'hA9, 16'h0077, 2);
      put_instr(8'h95, 16'h0020, 2);   // Wraps to 0010
      put_instr(8'h9D, 16'h02F8, 3);   // Carry to 03E8
      put_instr(8'h99, 16'h03FF, 3);
      put_instr(8'hB5, 16'h0015, 2);
      put_instr(8'h8D, 16'h0400, 3);
      put_instr(8'hB9, 16'h04F0, 3);
      put_instr(8'h8D, 16'h0401, 3);
      put_instr(8'hAE, 16'h0500, 3);
      put_instr(8'hAC, 16'h0502, 3);
      put_instr(8'hBD, 16'h0500, 3);
      put_instr(8'h8D, 16'h0402, 3);
      put_instr(8'hA6, 16'h0031, 2);
      put_instr(8'hA0, 16'h0004, 2);
      put_instr(8'hBD, 16'h0500, 3);
      put_instr(8'h99, 16'h0403, 3);
      put_instr(halt_op, 16'h0000, 1);
      run_program();
      check_range(16'h0010, 16'h0010);
      check_range(16'h03E8, 16'h03E8);
      check_range(16'h0400, 16'h0410);

      // Indirect modes and JMP indirect
      hold_reset();
      load_byte(16'h00FF, 8'h20);
      load_byte(16'h0000, 8'h06);
      load_byte(16'h0040, 8'hF0);
      load_byte(16'h0041, 8'h06);
      load_byte(16'h0042, 8'hF8);
      load_byte(16'h0043, 8'h08);
      load_byte(16'h0045, 8'h20);
      load_byte(16'h0046, 8'h09);
      load_byte(16'h0918, 8'h5C);
      load_byte(16'h0920, 8'h33);
      load_byte(16'h0640, 8'h00);
      load_byte(16'h0641, 8'h84);
      load_byte(16'h06FF, 8'h00);
      load_byte(16'h0700, 8'h85);
      set_vector(16'h8300);
      put_instr(8'hA2, 16'h0001, 2);
      put_instr(8'hA0, 16'h0020, 2);
      put_instr(8'hA9, 16'h00D4, 2);
      put_instr(8'h81, 16'h00FE, 2);   // Pointer at 00FF and 0000
      put_instr(8'hA9, 16'h00E1, 2);
      put_instr(8'h91, 16'h0040, 2);
      put_instr(8'hB1, 16'h0042, 2);
      put_instr(8'h8D, 16'h0630, 3);
      put_instr(8'hA1, 16'h0044, 2);
      put_instr(8'h8D, 16'h0631, 3);
      put_instr(8'h6C, 16'h0640, 3);
      put_instr(halt_op, 16'h0000, 1);
      cursor = 16'h8400;
      put_instr(8'hA9, 16'h0099, 2);
      put_instr(8'h8D, 16'h0632, 3);
      put_instr(8'h6C, 16'h06FF, 3);   // Pointer crosses a page
      put_instr(halt_op, 16'h0000, 1);
      cursor = 16'h8500;
      put_instr(8'hA9, 16'h0066, 2);
      put_instr(8'h8D, 16'h0633, 3);
      put_instr(halt_op, 16'h0000, 1);
      run_program();
      check_range(16'h0620, 16'h0633);
      check_range(16'h0710, 16'h0710);

      // Random program, values below 3F keep every address under 4000
      hold_reset();
      for (int a = 0; a < 16'h4000; a++)
         load_byte(addr_t'(a), data_t'($unsigned($random(seed)) % 63));
      set_vector(16'h9000);
      for (int i = 0; i < 40; i++)
      begin
         op = opcode_pool[$unsigned($random(seed)) % 22];
         if (op == 8'h4C)
            put_instr(op, cursor + 16'd3, 3);
         else
            put_instr(op, {data_t'($unsigned($random(seed)) % 63),
                           data_t'($unsigned($random(seed)) % 63)}, instr_length(op[4:2]));
      end
      put_instr(halt_op, 16'h0000, 1);
      run_program();
      check_range(16'h0000, 16'h3FFF);

      // Halt holds and leaves memory alone
      for (int i = 0; i < 40; i++)
      begin
         @(negedge clk);
         assert (halted === 1'b1)
         else
         begin
            $display("Error: %0t ns halted is %b, expected 1", $time, halted);
            $display("tests failed");
            $fatal(1, "The CPU left the halted state");
         end
      end
      check_range(16'h0000, 16'h3FFF);
      hold_reset();
      assert (halted === 1'b0)
      else
      begin
         $display("Error: %0t ns halted is %b after reset, expected 0", $time, halted);
         $display("tests failed");
         $fatal(1, "Reset did not clear the halted flag");
      end

      $display("all tests passed");
      $finish;
   end

endmodule

// ==== m6502_system.f ====
+incdir+tb
source/m6502_bus_pkg.sv
source/m6502_isa_pkg.sv
source/mem_bus_if.sv
source/addr_req_if.sv
source/m6502_addr_unit.sv
source/m6502_cpu.sv
source/m6502_ram.sv
source/m6502_system.sv
tb/tb_m6502_system.sv

// ==== Bender.yml ====
package:
  name: m6502_system

sources:
  - source/m6502_bus_pkg.sv
  - source/m6502_isa_pkg.sv
  - source/mem_bus_if.sv
  - source/addr_req_if.sv
  - source/m6502_addr_unit.sv
  - source/m6502_cpu.sv
  - source/m6502_ram.sv
  - source/m6502_system.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_m6502_system.sv
